/* verilog/aluPkg.sv */
package aluPkg;

    // datapath widths
    localparam int dataWidth   = 8;
    localparam int nibbleWidth = 4;
    localparam int numNibbles  = dataWidth / nibbleWidth;

    // alu function, subtract is opAdd with inverted data
    typedef enum logic [2:0] {
        opAdd,
        opAnd,
        opEor,
        opOr,
        opShr
    } aluOp_e;

    // register select, regNone reads zero and never writes
    typedef enum logic [1:0] {
        regAc,
        regX,
        regY,
        regNone
    } regSel_e;

    // b operand comes straight off the data byte or inverted
    typedef enum logic {
        bData,
        bDataInv
    } bSrc_e;

    // carry into the low slice
    typedef enum logic [1:0] {
        carryZero,
        carryOne,
        carryFlag
    } carrySrc_e;

    // micro-operation as issued by the sequencer
    typedef struct packed {
        aluOp_e    aluOp;
        regSel_e   srcA;
        bSrc_e     srcB;
        carrySrc_e carrySrc;
        regSel_e   dest;
        logic      decimal;
        logic      setFlags;
    } microOp_t;

    // operands and control after the selector
    typedef struct packed {
        logic                 valid;
        aluOp_e               aluOp;
        logic [dataWidth-1:0] operandA;
        logic [dataWidth-1:0] operandB;
        logic                 carryIn;
        regSel_e              dest;
        logic                 decimal;
        logic                 subtract;
        logic                 setFlags;
    } stageOp_t;

    // one slice worth of alu output
    typedef struct packed {
        logic [nibbleWidth-1:0] result;
        logic                   carryOut;
        logic                   shiftOut;
    } sliceOut_t;

    // arithmetic flags only
    typedef struct packed {
        logic n;
        logic v;
        logic z;
        logic c;
    } statusFlags_t;

    // register write from the result stage
    typedef struct packed {
        logic                 valid;
        regSel_e              dest;
        logic [dataWidth-1:0] value;
    } writeback_t;

endpackage

/* verilog/aluNibble.sv */
`timescale 1ns/1ps

module aluNibble import aluPkg::*; (
    input  aluOp_e                 aluOp,
    input  logic [nibbleWidth-1:0] a,
    input  logic [nibbleWidth-1:0] b,
    input  logic                   carryIn,
    input  logic                   shiftIn,
    output sliceOut_t              out
);

    // sum with carry out on top
    logic [nibbleWidth:0] sum;

    assign sum = {1'b0, a} + {1'b0, b} + {{nibbleWidth{1'b0}}, carryIn};

    always_comb begin
        out.carryOut = 1'b0;
        // low bit always leaves toward the slice below
        out.shiftOut = b[0];
        case (aluOp)
            opAdd: begin
                out.result   = sum[nibbleWidth-1:0];
                out.carryOut = sum[nibbleWidth];
            end
            opAnd: begin
                out.result = a & b;
            end
            opEor: begin
                out.result = a ^ b;
            end
            opOr: begin
                out.result = a | b;
            end
            opShr: begin
                // shift acts on the b side, as in the original datapath
                out.result = {shiftIn, b[nibbleWidth-1:1]};
            end
            default: begin
                out.result = '0;
            end
        endcase
    end

endmodule

/* verilog/operandSelect.sv */
`timescale 1ns/1ps

module operandSelect import aluPkg::*; (
    input  logic                 phi2,
    input  logic                 rstAll,
    input  logic                 opValid,
    input  microOp_t             op,
    input  logic [dataWidth-1:0] dataIn,
    input  writeback_t           wb,
    input  statusFlags_t         status,
    output stageOp_t             stage
);

    // architectural registers
    logic [dataWidth-1:0] acReg;
    logic [dataWidth-1:0] xReg;
    logic [dataWidth-1:0] yReg;

    // next-stage operands
    logic [dataWidth-1:0] aSel;
    logic [dataWidth-1:0] bSel;
    logic                 cSel;

    // a side, stands in for the SB bus
    always_comb begin
        case (op.srcA)
            regAc:   aSel = acReg;
            regX:    aSel = xReg;
            regY:    aSel = yReg;
            default: aSel = '0;
        endcase
    end

    // b side, inverted data gives subtract
    assign bSel = (op.srcB == bDataInv) ? ~dataIn : dataIn;

    always_comb begin
        case (op.carrySrc)
            carryOne:  cSel = 1'b1;
            // flag as it stands before this edge
            carryFlag: cSel = status.c;
            default:   cSel = 1'b0;
        endcase
    end

    // register file write, no bypass to the read side
    always_ff @(posedge phi2) begin
        if (rstAll) begin
            acReg <= '0;
            xReg  <= '0;
            yReg  <= '0;
        end else if (wb.valid) begin
            case (wb.dest)
                regAc:   acReg <= wb.value;
                regX:    xReg  <= wb.value;
                regY:    yReg  <= wb.value;
                default: ;
            endcase
        end
    end

    // stage one latch
    always_ff @(posedge phi2) begin
        if (rstAll) begin
            stage <= '0;
        end else begin
            stage.valid    <= opValid;
            stage.aluOp    <= op.aluOp;
            stage.operandA <= aSel;
            stage.operandB <= bSel;
            stage.carryIn  <= cSel;
            stage.dest     <= op.dest;
            stage.decimal  <= op.decimal;
            stage.subtract <= (op.srcB == bDataInv);
            stage.setFlags <= op.setFlags;
        end
    end

    // issued op must carry a legal alu function
    assert property (@(posedge phi2) disable iff (rstAll)
        opValid |-> (op.aluOp inside {opAdd, opAnd, opEor, opOr, opShr}))
        else $error("operandSelect: bad aluOp issued");

endmodule

/* verilog/resultStage.sv */
`timescale 1ns/1ps

module resultStage import aluPkg::*; (
    input  logic                              phi2,
    input  logic                              rstAll,
    input  stageOp_t                          stage,
    input  sliceOut_t [numNibbles-1:0]        slices,
    output writeback_t                        wb,
    output statusFlags_t                      status
);

    logic [dataWidth-1:0] aluByte;
    logic                 aluAcr;
    logic                 aluAvr;

    // adder hold register and latched op fields
    logic                 holdValid;
    logic [dataWidth-1:0] holdByte;
    logic                 holdAcr;
    logic                 holdHc;
    logic                 holdAvr;
    aluOp_e               holdAluOp;
    regSel_e              holdDest;
    logic                 holdDecimal;
    logic                 holdSubtract;
    logic                 holdSetFlags;

    // after decimal adjust
    logic [dataWidth-1:0] adjByte;
    logic                 cFinal;

    // writeback register
    logic                 wbValid;
    regSel_e              wbDest;
    logic [dataWidth-1:0] wbValue;

    // gather the slices back into a byte
    always_comb begin
        for (int k = 0; k < numNibbles; k++) begin
            aluByte[k*nibbleWidth +: nibbleWidth] = slices[k].result;
        end
    end

    // carry out of the top for add, bit 0 for the shift
    assign aluAcr = (stage.aluOp == opAdd) ? slices[numNibbles-1].carryOut :
                    (stage.aluOp == opShr) ? slices[0].shiftOut : 1'b0;

    // signed overflow on add only
    assign aluAvr = (stage.aluOp == opAdd) &&
                    (stage.operandA[dataWidth-1] == stage.operandB[dataWidth-1]) &&
                    (aluByte[dataWidth-1] != stage.operandA[dataWidth-1]);

    always_ff @(posedge phi2) begin
        if (rstAll) begin
            holdValid <= 1'b0;
        end else begin
            holdValid <= stage.valid;
        end
    end

    always_ff @(posedge phi2) begin
        holdByte     <= aluByte;
        holdAcr      <= aluAcr;
        // low slice carry is the half carry
        holdHc       <= slices[0].carryOut;
        holdAvr      <= aluAvr;
        holdAluOp    <= stage.aluOp;
        holdDest     <= stage.dest;
        holdDecimal  <= stage.decimal;
        holdSubtract <= stage.subtract;
        holdSetFlags <= stage.setFlags;
    end

    // bcd correction off the held binary result
    always_comb begin
        adjByte = holdByte;
        cFinal  = holdAcr;
        if (holdDecimal && !holdSubtract) begin
            if (holdByte[3:0] > 4'd9 || holdHc) begin
                adjByte = adjByte + 8'h06;
            end
            // decimal carry out of the high digit
            if (holdAcr || holdByte > 8'h99) begin
                adjByte = adjByte + 8'h60;
                cFinal  = 1'b1;
            end
        end else if (holdDecimal && holdSubtract) begin
            // borrow out of a digit shows as a clear carry
            if (!holdHc) begin
                adjByte = adjByte - 8'h06;
            end
            if (!holdAcr) begin
                adjByte = adjByte - 8'h60;
            end
        end
    end

    always_ff @(posedge phi2) begin
        if (rstAll) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= holdValid;
        end
    end

    always_ff @(posedge phi2) begin
        wbDest  <= holdDest;
        wbValue <= adjByte;
    end

    assign wb = '{valid: wbValid, dest: wbDest, value: wbValue};

    // n and z always, c and v depend on the function
    always_ff @(posedge phi2) begin
        if (rstAll) begin
            status <= '0;
        end else if (holdValid && holdSetFlags) begin
            status.n <= adjByte[dataWidth-1];
            status.z <= (adjByte == '0);
            case (holdAluOp)
                opAdd: begin
                    status.c <= cFinal;
                    status.v <= holdAvr;
                end
                opShr: begin
                    status.c <= holdAcr;
                end
                // logic ops keep c and v
                default: ;
            endcase
        end
    end

    // decimal mode from the selector only ever pairs with add
    assert property (@(posedge phi2) disable iff (rstAll)
        stage.valid && stage.decimal |-> stage.aluOp == opAdd)
        else $error("resultStage: decimal with non-add op");

endmodule

/* verilog/datapathCore.sv */
`timescale 1ns/1ps

module datapathCore import aluPkg::*; (
    input  logic                 phi2,
    input  logic                 rstAll,
    input  logic                 opValid,
    input  microOp_t             op,
    input  logic [dataWidth-1:0] dataIn,
    output writeback_t           wbOut,
    output statusFlags_t         status
);

    stageOp_t                   stage;
    sliceOut_t [numNibbles-1:0] slices;

    // carry runs upward, shift bits run downward
    logic [numNibbles:0] carryChain;
    logic [numNibbles:0] shiftChain;

    operandSelect i_operandSelect (
        .phi2    (phi2),
        .rstAll  (rstAll),
        .opValid (opValid),
        .op      (op),
        .dataIn  (dataIn),
        .wb      (wbOut),
        .status  (status),
        .stage   (stage)
    );

    assign carryChain[0]          = stage.carryIn;
    // carry in also lands in bit 7 on the shift
    assign shiftChain[numNibbles] = stage.carryIn;

    for (genvar k = 0; k < numNibbles; k++) begin : g_slice
        aluNibble i_aluNibble (
            .aluOp   (stage.aluOp),
            .a       (stage.operandA[k*nibbleWidth +: nibbleWidth]),
            .b       (stage.operandB[k*nibbleWidth +: nibbleWidth]),
            .carryIn (carryChain[k]),
            .shiftIn (shiftChain[k+1]),
            .out     (slices[k])
        );
        assign carryChain[k+1] = slices[k].carryOut;
        assign shiftChain[k]   = slices[k].shiftOut;
    end

    resultStage i_resultStage (
        .phi2   (phi2),
        .rstAll (rstAll),
        .stage  (stage),
        .slices (slices),
        .wb     (wbOut),
        .status (status)
    );

endmodule

/* verif/tbDatapathCore.sv */
`timescale 1ns/1ps

module tbDatapathCore import aluPkg::*; ();

    localparam int numRows    = 17;
    localparam int numRandom  = 40;
    localparam int numOps     = numRows + numRandom;
    localparam int cycleLimit = numOps * 3 + 20;

    logic                 phi2;
    logic                 rstAll;
    logic                 opValid;
    microOp_t             op;
    logic [dataWidth-1:0] dataIn;
    writeback_t           wbOut;
    statusFlags_t         status;

    // stimulus and expected result per issued op
    string        opName     [numOps];
    microOp_t     opList     [numOps];
    logic [7:0]   dataList   [numOps];
    logic [7:0]   expValue   [numOps];
    statusFlags_t expFlags   [numOps];
    // reference model state, flags listed in issue order
    logic [7:0]   modelValue [numOps];
    statusFlags_t modelFlags [numOps];
    logic [7:0]   regFile    [4];
    int           appliedCount;
    int           rowCount;
    int           passCount;
    int           failCount;
    int           cycleCount;
    logic [15:0]  lfsrState;

    datapathCore i_dut (
        .phi2    (phi2),
        .rstAll  (rstAll),
        .opValid (opValid),
        .op      (op),
        .dataIn  (dataIn),
        .wbOut   (wbOut),
        .status  (status)
    );

    initial begin
        phi2 = 1'b0;
        forever #50 phi2 = ~phi2;
    end

    // galois form, taps for a 16 bit maximal sequence
    function automatic logic nextRandomBit();
        logic lowBit;
        lowBit = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (lowBit) begin
            lfsrState = lfsrState ^ 16'hB400;
        end
        return lowBit;
    endfunction

    function automatic logic [7:0] takeBits(input int n);
        logic [7:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[6:0], nextRandomBit()};
        end
        return bits;
    endfunction

    task automatic addRow(input string name, input aluOp_e aluFn, input regSel_e srcSel,
                          input bSrc_e bSel, input carrySrc_e cSel, input regSel_e dstSel,
                          input logic dec, input logic flagsOn, input logic [7:0] data,
                          input logic [7:0] value, input statusFlags_t flags);
        opName[rowCount]   = name;
        opList[rowCount]   = '{aluOp: aluFn, srcA: srcSel, srcB: bSel, carrySrc: cSel,
                               dest: dstSel, decimal: dec, setFlags: flagsOn};
        dataList[rowCount] = data;
        expValue[rowCount] = value;
        expFlags[rowCount] = flags;
        rowCount++;
    endtask

    // expected flags as n v z c; a register write shows four issues later,
    // the c flag three issues later
    task automatic fillTable();
        addRow("load ac 7f", opAdd, regNone, bData, carryZero, regAc, 1'b0, 1'b1,
               8'h7F, 8'h7F, 4'b0000);
        addRow("load x 45", opAdd, regNone, bData, carryZero, regX, 1'b0, 1'b1,
               8'h45, 8'h45, 4'b0000);
        addRow("load y 99", opAdd, regNone, bData, carryZero, regY, 1'b0, 1'b1,
               8'h99, 8'h99, 4'b1000);
        addRow("add ff plus 01", opAdd, regNone, bData, carryOne, regNone, 1'b0, 1'b1,
               8'hFF, 8'h00, 4'b0011);
        addRow("add 7f plus 01", opAdd, regAc, bData, carryZero, regAc, 1'b0, 1'b1,
               8'h01, 8'h80, 4'b1100);
        addRow("bcd 45 plus 38", opAdd, regX, bData, carryZero, regX, 1'b1, 1'b1,
               8'h38, 8'h83, 4'b1000);
        addRow("bcd 99 plus 01", opAdd, regY, bData, carryZero, regY, 1'b1, 1'b1,
               8'h01, 8'h00, 4'b0011);
        addRow("or", opOr, regX, bData, carryZero, regNone, 1'b0, 1'b1,
               8'h0C, 8'h4D, 4'b0001);
        addRow("eor", opEor, regAc, bData, carryZero, regNone, 1'b0, 1'b1,
               8'hFF, 8'h7F, 4'b0001);
        // c is set by the bcd add three issues back
        addRow("add with c flag", opAdd, regAc, bData, carryFlag, regNone, 1'b0, 1'b1,
               8'hFF, 8'h80, 4'b1001);
        addRow("load y 50", opAdd, regNone, bData, carryZero, regY, 1'b0, 1'b1,
               8'h50, 8'h50, 4'b0000);
        addRow("shift carry 1", opShr, regNone, bData, carryOne, regAc, 1'b0, 1'b1,
               8'h02, 8'h81, 4'b1000);
        addRow("shift carry 0", opShr, regNone, bData, carryZero, regNone, 1'b0, 1'b1,
               8'h03, 8'h01, 4'b0001);
        addRow("and", opAnd, regAc, bData, carryZero, regNone, 1'b0, 1'b1,
               8'hFF, 8'h80, 4'b1001);
        addRow("bcd 50 minus 25", opAdd, regY, bDataInv, carryOne, regAc, 1'b1, 1'b1,
               8'h25, 8'h25, 4'b0001);
        // reads ac right behind the write above, old value expected
        addRow("no forwarding", opAdd, regAc, bData, carryZero, regNone, 1'b0, 1'b1,
               8'h00, 8'h81, 4'b1000);
        addRow("quiet op", opAdd, regNone, bData, carryZero, regNone, 1'b0, 1'b0,
               8'h33, 8'h33, 4'b1000);
    endtask

    task automatic makeRandom(input int j);
        logic [7:0] pick;
        microOp_t   rop;
        pick = takeBits(3) % 8'd5;
        rop.aluOp = aluOp_e'(pick[2:0]);
        pick = takeBits(2);
        rop.srcA = regSel_e'(pick[1:0]);
        pick = takeBits(1);
        rop.srcB = bSrc_e'(pick[0]);
        pick = takeBits(2) % 8'd3;
        rop.carrySrc = carrySrc_e'(pick[1:0]);
        pick = takeBits(2);
        rop.dest = regSel_e'(pick[1:0]);
        pick = takeBits(1);
        rop.setFlags = pick[0];
        // bcd only pairs with add
        rop.decimal = 1'b0;
        if (rop.aluOp == opAdd) begin
            pick = takeBits(1);
            rop.decimal = pick[0];
        end
        opList[j]   = rop;
        dataList[j] = takeBits(8);
        opName[j]   = $sformatf("random %0d", j - numRows);
    endtask

    // byte result with carry and overflow, straight from the 6502 rules
    task automatic predict(input aluOp_e aluFn, input logic [7:0] a, input logic [7:0] b,
                           input logic cin, input logic dec, input logic sub,
                           output logic [7:0] value, output logic carry,
                           output logic overflow);
        logic [8:0] sum;
        logic [4:0] lowSum;
        sum      = {1'b0, a} + {1'b0, b} + {8'b0, cin};
        lowSum   = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'b0, cin};
        value    = 8'h00;
        carry    = 1'b0;
        overflow = 1'b0;
        case (aluFn)
            opAdd: begin
                value    = sum[7:0];
                carry    = sum[8];
                overflow = (a[7] == b[7]) && (sum[7] != a[7]);
                if (dec && !sub) begin
                    if (sum[3:0] > 4'd9 || lowSum[4]) begin
                        value += 8'h06;
                    end
                    if (sum[8] || sum[7:0] > 8'h99) begin
                        value += 8'h60;
                        carry = 1'b1;
                    end
                end else if (dec) begin
                    // clear carry means the digit borrowed
                    if (!lowSum[4]) begin
                        value -= 8'h06;
                    end
                    if (!sum[8]) begin
                        value -= 8'h60;
                    end
                end
            end
            opAnd: value = a & b;
            opEor: value = a ^ b;
            opOr:  value = a | b;
            opShr: begin
                value = {cin, b[7:1]};
                carry = b[0];
            end
            default: value = 8'h00;
        endcase
    endtask

    function automatic statusFlags_t updateFlags(input statusFlags_t prev, input microOp_t mop,
                                                 input logic [7:0] value, input logic carry,
                                                 input logic overflow);
        statusFlags_t next;
        next = prev;
        if (mop.setFlags) begin
            next.n = value[7];
            next.z = (value == 8'h00);
            if (mop.aluOp == opAdd) begin
                next.c = carry;
                next.v = overflow;
            end else if (mop.aluOp == opShr) begin
                next.c = carry;
            end
        end
        return next;
    endfunction

    // model op j as the DUT sees it, then drive it
    task automatic issueOp(input int j);
        logic [7:0]   a;
        logic [7:0]   b;
        logic [7:0]   value;
        logic         cin;
        logic         carry;
        logic         overflow;
        statusFlags_t seen;
        statusFlags_t prev;
        while (appliedCount <= j - 4) begin
            if (opList[appliedCount].dest != regNone) begin
                regFile[opList[appliedCount].dest] = modelValue[appliedCount];
            end
            appliedCount++;
        end
        seen = (j >= 3) ? modelFlags[j-3] : statusFlags_t'(4'b0000);
        prev = (j >= 1) ? modelFlags[j-1] : statusFlags_t'(4'b0000);
        a = (opList[j].srcA == regNone) ? 8'h00 : regFile[opList[j].srcA];
        b = (opList[j].srcB == bDataInv) ? ~dataList[j] : dataList[j];
        case (opList[j].carrySrc)
            carryOne:  cin = 1'b1;
            carryFlag: cin = seen.c;
            default:   cin = 1'b0;
        endcase
        predict(opList[j].aluOp, a, b, cin, opList[j].decimal,
                opList[j].srcB == bDataInv, value, carry, overflow);
        modelValue[j] = value;
        modelFlags[j] = updateFlags(prev, opList[j], value, carry, overflow);
        if (j >= numRows) begin
            expValue[j] = value;
            expFlags[j] = modelFlags[j];
        end
        opValid = 1'b1;
        op      = opList[j];
        dataIn  = dataList[j];
    endtask

    task automatic checkOp(input int k);
        logic good;
        good = 1'b1;
        if (!wbOut.valid) begin
            $display("%s: writeback valid did not go high when due", opName[k]);
            good = 1'b0;
        end
        if (wbOut.dest != opList[k].dest) begin
            $display("[ERROR] %s: dest expected %0d actual %0d", opName[k],
                     opList[k].dest, wbOut.dest);
            good = 1'b0;
        end
        if (wbOut.value != expValue[k]) begin
            $display("[ERROR] %s: value expected %h actual %h", opName[k],
                     expValue[k], wbOut.value);
            good = 1'b0;
        end
        if (status != expFlags[k]) begin
            $display("[ERROR] %s: nvzc expected %b actual %b", opName[k],
                     expFlags[k], status);
            good = 1'b0;
        end
        if (good) begin
            passCount++;
            $display("[PASS] %s", opName[k]);
        end else begin
            failCount++;
            $display("[FAIL] %s", opName[k]);
        end
    endtask

    initial begin
        rstAll       = 1'b1;
        opValid      = 1'b0;
        op           = '0;
        dataIn       = '0;
        rowCount     = 0;
        passCount    = 0;
        failCount    = 0;
        appliedCount = 0;
        lfsrState    = 16'd42;
        for (int r = 0; r < 4; r++) begin
            regFile[r] = 8'h00;
        end
        fillTable();
        for (int j = numRows; j < numOps; j++) begin
            makeRandom(j);
        end
        repeat (3) @(posedge phi2);
        #5;
        rstAll = 1'b0;
        // nothing issued yet, all quiet
        if (wbOut.valid || status != 4'b0000) begin
            $display("[ERROR] reset state: valid and nvzc expected 0 0000 actual %b %b",
                     wbOut.valid, status);
            failCount++;
        end else begin
            passCount++;
            $display("[PASS] reset state");
        end
        // one extra cycle after the last op to see valid drop
        for (int cyc = 0; cyc < numOps + 4; cyc++) begin
            @(posedge phi2);
            #5;
            if (cyc >= 3 && cyc < numOps + 3) begin
                checkOp(cyc - 3);
            end else if (wbOut.valid) begin
                $display("writeback valid went high with no op due");
                failCount++;
            end
            if (cyc < numOps) begin
                issueOp(cyc);
            end else begin
                opValid = 1'b0;
                op      = '0;
                dataIn  = '0;
            end
        end
        $display("%0d tests, %0d passed, %0d failed", passCount + failCount,
                 passCount, failCount);
        if (failCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // run length bound from the op count
    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge phi2);
            cycleCount++;
        end
        $display("run did not finish within %0d cycles", cycleLimit);
        $display("sim failed");
        $finish;
    end

endmodule

/* all.f */
verilog/aluPkg.sv
verilog/aluNibble.sv
verilog/operandSelect.sv
verilog/resultStage.sv
verilog/datapathCore.sv
verif/tbDatapathCore.sv

/* run.sh */
#!/bin/sh
# build and run the datapath testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tbDatapathCore \
    -o simDatapath \
    -f all.f > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    exit 1
fi

if [ ! -x ./obj_dir/simDatapath ]; then
    echo "simulation binary missing"
    exit 1
fi

./obj_dir/simDatapath > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

cat sim.log

if grep -q "sim failed" sim.log; then
    echo "FAIL"
    exit 1
fi

echo "PASS"
exit 0
